// File: vlog.f
+incdir+tests
src/soc_bus_pkg.sv
src/soc_periph_pkg.sv
src/wb_xbar.sv
src/ram_main.sv
src/gpio.sv
src/rv_timer.sv
src/rv_plic.sv
src/soc_top.sv
tests/soc_top_tb.sv

// File: run.sh
#!/bin/sh
set -e

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module soc_top_tb -o Vsoc_top_tb

out=$(./obj_dir/Vsoc_top_tb || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'TB PASSED'; then
	exit 0
fi
exit 1

// File: tests/soc_tb_tasks.svh
`ifndef SOC_TB_TASKS_SVH
`define SOC_TB_TASKS_SVH

localparam int BUS_TIMEOUT = 16; // Cycles before an access is abandoned.

task automatic check_eq(input string name, input bus_data_t expected, input bus_data_t actual);
	assert (actual == expected) else begin
		$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
		end_in_failure();
	end
endtask

task automatic check_reply(input string name, input logic ack, input logic err, input int waits);
	check_eq({name, " ack"}, 32'd1, bus_data_t'(ack));
	check_eq({name, " err"}, 32'd0, bus_data_t'(err));
	check_eq({name, " wait states"}, 32'd1, bus_data_t'(waits));
endtask

////////////////////////////////////////
// Wishbone classic host

task automatic bus_cycle(input logic we, input bus_addr_t adr, input bus_data_t wdat,
		input bus_sel_t sel, output bus_data_t rdat, output logic ack, output logic err,
		output int waits);
	@(posedge usb_clk);
	#1;
	wb_cyc  = 1'b1;
	wb_stb  = 1'b1;
	wb_we   = we;
	wb_adr  = adr;
	wb_wdat = wdat;
	wb_sel  = sel;
	waits   = 0;
	#1;
	ack = wb_ack; // A reply without wait state shows up here.
	err = wb_err;
	while (!(ack || err) && waits < BUS_TIMEOUT) begin
		@(posedge usb_clk);
		#1;
		waits++;
		ack = wb_ack;
		err = wb_err;
	end
	rdat   = wb_rdat; // Valid together with ack.
	wb_stb = 1'b0;
	wb_cyc = 1'b0;
	wb_we  = 1'b0;
	if (!(ack || err)) begin
		stop_with_error($sformatf("No ack or err for address %h within %0d cycles",
			adr, BUS_TIMEOUT));
	end
endtask

task automatic write_reg(input string name, input bus_addr_t adr, input bus_data_t wdat,
		input bus_sel_t sel);
	bus_data_t rdat;
	logic      ack;
	logic      err;
	int        waits;
	bus_cycle(1'b1, adr, wdat, sel, rdat, ack, err, waits);
	check_reply(name, ack, err, waits);
endtask

task automatic read_reg(input string name, input bus_addr_t adr, output bus_data_t rdat);
	logic ack;
	logic err;
	int   waits;
	bus_cycle(1'b0, adr, '0, 4'hf, rdat, ack, err, waits);
	check_reply(name, ack, err, waits);
endtask

// Reads until the value shows up or the read budget runs out.
task automatic poll_reg(input string name, input bus_addr_t adr, input bus_data_t expected,
		input int max_reads);
	bus_data_t rdat;
	int        reads;
	reads = 0;
	rdat  = ~expected;
	while (rdat != expected && reads < max_reads) begin
		read_reg(name, adr, rdat);
		reads++;
	end
	if (rdat != expected) begin
		stop_with_error($sformatf("%s: register did not reach %h within %0d reads, last %h",
			name, expected, max_reads, rdat));
	end
endtask

task automatic wait_irq(input string name, input logic level, input int max_cycles);
	int cycles;
	cycles = 0;
	while (irq !== level && cycles < max_cycles) begin
		@(posedge usb_clk);
		#1;
		cycles++;
	end
	if (irq !== level) begin
		stop_with_error($sformatf("%s: irq did not reach %b within %0d cycles",
			name, level, max_cycles));
	end
endtask

`endif

// File: tests/soc_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top_tb
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;
();

	logic      usb_clk;
	logic      arst_n;
	logic      wb_cyc;
	logic      wb_stb;
	logic      wb_we;
	bus_addr_t wb_adr;
	bus_data_t wb_wdat;
	bus_sel_t  wb_sel;
	bus_data_t wb_rdat;
	logic      wb_ack;
	logic      wb_err;
	gpio_t     gpio_in;
	gpio_t     gpio_out;
	gpio_t     gpio_oe;
	logic      irq;
	irq_id_t   irq_id;
	integer    seed;
	bus_data_t ram_model [RAM_WORDS];
	ram_addr_t ram_idx [16];

	task automatic end_in_failure();
		$display("TB FAILED");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic stop_with_error(input string why);
		$display("%s", why);
		end_in_failure();
	endtask

	`include "soc_tb_tasks.svh"

	// Only the selected bytes take the new value.
	function automatic bus_data_t merge_bytes(input bus_data_t old_word, input bus_data_t new_word,
			input bus_sel_t sel);
		bus_data_t res;
		res = old_word;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = new_word[8*b +: 8];
			end
		end
		return res;
	endfunction

	function automatic bus_addr_t reg_addr(input bus_addr_t base, input reg_addr_t off);
		return base + {20'b0, off, 2'b00};
	endfunction

	function automatic bus_addr_t ram_addr(input ram_addr_t idx);
		return ADDR_SPACE_RAM_MAIN + {22'b0, idx, 2'b00};
	endfunction

	soc_top i_soc_top (
		.usb_clk   (usb_clk),
		.arst_n_i  (arst_n),
		.wb_cyc_i  (wb_cyc),
		.wb_stb_i  (wb_stb),
		.wb_we_i   (wb_we),
		.wb_adr_i  (wb_adr),
		.wb_dat_i  (wb_wdat),
		.wb_sel_i  (wb_sel),
		.wb_dat_o  (wb_rdat),
		.wb_ack_o  (wb_ack),
		.wb_err_o  (wb_err),
		.gpio_i    (gpio_in),
		.gpio_o    (gpio_out),
		.gpio_oe_o (gpio_oe),
		.irq_o     (irq),
		.irq_id_o  (irq_id)
	);

	initial begin
		usb_clk = 1'b0;
		forever #5 usb_clk = ~usb_clk;
	end

	initial begin : stimulus
		bus_data_t rdat;
		bus_data_t wdat;
		bus_sel_t  sel;
		logic      ack;
		logic      err;
		int        waits;
		int        pick;
		gpio_t     out_val;
		gpio_t     oe_val;

		seed    = 32'hc51695f2;
		arst_n  = 1'b0;
		wb_cyc  = 1'b0;
		wb_stb  = 1'b0;
		wb_we   = 1'b0;
		wb_adr  = '0;
		wb_wdat = '0;
		wb_sel  = '0;
		gpio_in = '0;
		repeat (8) @(posedge usb_clk);
		#1;
		arst_n = 1'b1;
		repeat (3) @(posedge usb_clk); // Synchronizer release.
		#1;

		////////////////////////////////////////
		// Reset state
		check_eq("reset ack", 32'd0, bus_data_t'(wb_ack));
		check_eq("reset err", 32'd0, bus_data_t'(wb_err));
		check_eq("reset gpio_o", 32'd0, bus_data_t'(gpio_out));
		check_eq("reset gpio_oe_o", 32'd0, bus_data_t'(gpio_oe));
		check_eq("reset irq", 32'd0, bus_data_t'(irq));
		check_eq("reset irq id", 32'd0, bus_data_t'(irq_id));

		////////////////////////////////////////
		// RAM with byte selects
		for (int i = 0; i < 16; i++) begin
			ram_idx[i] = ram_addr_t'($random(seed));
			wdat = $random(seed);
			write_reg("ram fill", ram_addr(ram_idx[i]), wdat, 4'hf);
			ram_model[ram_idx[i]] = wdat;
		end
		for (int i = 0; i < 32; i++) begin
			pick = int'($unsigned($random(seed)) % 16);
			wdat = $random(seed);
			sel  = bus_sel_t'($random(seed));
			write_reg("ram partial write", ram_addr(ram_idx[pick]), wdat, sel);
			ram_model[ram_idx[pick]] = merge_bytes(ram_model[ram_idx[pick]], wdat, sel);
			read_reg("ram read", ram_addr(ram_idx[pick]), rdat);
			check_eq("ram read data", ram_model[ram_idx[pick]], rdat);
		end

		////////////////////////////////////////
		// Address decode
		bus_cycle(1'b0, 32'h2000_0000, '0, 4'hf, rdat, ack, err, waits);
		check_eq("unmapped read err", 32'd1, bus_data_t'(err));
		check_eq("unmapped read ack", 32'd0, bus_data_t'(ack));
		check_eq("unmapped read data", 32'd0, rdat);
		check_eq("unmapped read wait states", 32'd1, bus_data_t'(waits));
		bus_cycle(1'b1, ADDR_SPACE_RAM_MAIN + 32'h400, 32'hdead_beef, 4'hf, rdat, ack, err,
			waits);
		check_eq("past ram write err", 32'd1, bus_data_t'(err));
		check_eq("past ram write ack", 32'd0, bus_data_t'(ack));
		read_reg("gpio undefined offset", reg_addr(ADDR_SPACE_GPIO, 10'd8), rdat);
		check_eq("gpio undefined offset data", 32'd0, rdat);
		read_reg("timer undefined offset", reg_addr(ADDR_SPACE_TIMER, 10'd5), rdat);
		check_eq("timer undefined offset data", 32'd0, rdat);
		read_reg("plic undefined offset", reg_addr(ADDR_SPACE_PLIC, 10'd7), rdat);
		check_eq("plic undefined offset data", 32'd0, rdat);

		////////////////////////////////////////
		// GPIO
		out_val = gpio_t'($random(seed));
		oe_val  = gpio_t'($random(seed));
		write_reg("gpio data_out", reg_addr(ADDR_SPACE_GPIO, GPIO_DATA_OUT),
			bus_data_t'(out_val), 4'hf);
		check_eq("gpio_o after write", bus_data_t'(out_val), bus_data_t'(gpio_out));
		write_reg("gpio data_oe", reg_addr(ADDR_SPACE_GPIO, GPIO_DATA_OE),
			bus_data_t'(oe_val), 4'hf);
		check_eq("gpio_oe_o after write", bus_data_t'(oe_val), bus_data_t'(gpio_oe));
		gpio_in = 8'ha5;
		poll_reg("gpio data_in", reg_addr(ADDR_SPACE_GPIO, GPIO_DATA_IN), 32'h0000_00a5, 8);
		read_reg("gpio intr_state", reg_addr(ADDR_SPACE_GPIO, GPIO_INTR_STATE), rdat);
		check_eq("gpio intr_state after rise", 32'h0000_00a5, rdat);
		write_reg("gpio intr_state clear", reg_addr(ADDR_SPACE_GPIO, GPIO_INTR_STATE),
			32'h0000_00ff, 4'hf);
		read_reg("gpio intr_state", reg_addr(ADDR_SPACE_GPIO, GPIO_INTR_STATE), rdat);
		check_eq("gpio intr_state cleared", 32'd0, rdat);
		gpio_in = 8'h00;
		poll_reg("gpio data_in low", reg_addr(ADDR_SPACE_GPIO, GPIO_DATA_IN), 32'd0, 8);
		read_reg("gpio intr_state", reg_addr(ADDR_SPACE_GPIO, GPIO_INTR_STATE), rdat);
		check_eq("gpio intr_state after fall", 32'd0, rdat);
		gpio_in = 8'h10;
		poll_reg("gpio pin 4 rise", reg_addr(ADDR_SPACE_GPIO, GPIO_INTR_STATE), 32'h10, 8);
		write_reg("gpio pin 4 clear", reg_addr(ADDR_SPACE_GPIO, GPIO_INTR_STATE),
			32'h10, 4'hf);
		read_reg("gpio intr_state", reg_addr(ADDR_SPACE_GPIO, GPIO_INTR_STATE), rdat);
		check_eq("gpio pin 4 cleared", 32'd0, rdat);

		////////////////////////////////////////
		// Timer through the PLIC
		write_reg("plic enable timer", reg_addr(ADDR_SPACE_PLIC, PLIC_ENABLE), 32'h100, 4'hf);
		write_reg("timer mtimecmp", reg_addr(ADDR_SPACE_TIMER, TIMER_MTIMECMP), 32'd40, 4'hf);
		write_reg("timer intr_enable", reg_addr(ADDR_SPACE_TIMER, TIMER_INTR_ENABLE),
			32'd1, 4'hf);
		write_reg("timer ctrl", reg_addr(ADDR_SPACE_TIMER, TIMER_CTRL), 32'd1, 4'hf);
		check_eq("irq before compare", 32'd0, bus_data_t'(irq));
		wait_irq("timer irq", 1'b1, 200);
		check_eq("timer irq id", 32'd9, bus_data_t'(irq_id));
		read_reg("plic claim", reg_addr(ADDR_SPACE_PLIC, PLIC_CLAIM), rdat);
		check_eq("timer claim id", 32'd9, rdat);
		check_eq("irq after timer claim", 32'd0, bus_data_t'(irq));
		read_reg("plic pending", reg_addr(ADDR_SPACE_PLIC, PLIC_PENDING), rdat);
		check_eq("timer still pending", 32'h100, rdat & 32'h100);
		check_eq("irq while in service", 32'd0, bus_data_t'(irq));
		write_reg("plic complete", reg_addr(ADDR_SPACE_PLIC, PLIC_CLAIM), 32'd9, 4'hf);
		check_eq("irq after timer complete", 32'd1, bus_data_t'(irq));
		check_eq("irq id after timer complete", 32'd9, bus_data_t'(irq_id));
		write_reg("timer intr off", reg_addr(ADDR_SPACE_TIMER, TIMER_INTR_ENABLE),
			32'd0, 4'hf);
		wait_irq("timer irq off", 1'b0, 16);

		////////////////////////////////////////
		// Priority and masking
		write_reg("gpio intr_enable", reg_addr(ADDR_SPACE_GPIO, GPIO_INTR_ENABLE),
			32'h24, 4'hf);
		write_reg("plic enable gpio", reg_addr(ADDR_SPACE_PLIC, PLIC_ENABLE), 32'h024, 4'hf);
		gpio_in = 8'h24; // Pins 2 and 5 rise together.
		wait_irq("gpio irq", 1'b1, 16);
		check_eq("lowest gpio id", 32'd3, bus_data_t'(irq_id));
		read_reg("plic claim", reg_addr(ADDR_SPACE_PLIC, PLIC_CLAIM), rdat);
		check_eq("gpio claim id", 32'd3, rdat);
		check_eq("irq id after claim of 3", 32'd6, bus_data_t'(irq_id));
		check_eq("irq after claim of 3", 32'd1, bus_data_t'(irq));
		write_reg("plic mask pin 5", reg_addr(ADDR_SPACE_PLIC, PLIC_ENABLE), 32'h004, 4'hf);
		check_eq("irq with pin 5 masked", 32'd0, bus_data_t'(irq));
		read_reg("plic pending", reg_addr(ADDR_SPACE_PLIC, PLIC_PENDING), rdat);
		check_eq("gpio sources pending", 32'h024, rdat & 32'h024);
		check_eq("irq still low", 32'd0, bus_data_t'(irq));
		write_reg("plic complete", reg_addr(ADDR_SPACE_PLIC, PLIC_CLAIM), 32'd3, 4'hf);
		check_eq("irq after complete of 3", 32'd1, bus_data_t'(irq));
		check_eq("irq id after complete of 3", 32'd3, bus_data_t'(irq_id));

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;
(
	input  wire logic      usb_clk,
	input  wire logic      arst_n_i,
	input  wire logic      wb_cyc_i,
	input  wire logic      wb_stb_i,
	input  wire logic      wb_we_i,
	input  wire bus_addr_t wb_adr_i,
	input  wire bus_data_t wb_dat_i,
	input  wire bus_sel_t  wb_sel_i,
	output bus_data_t      wb_dat_o,
	output logic           wb_ack_o,
	output logic           wb_err_o,
	input  wire gpio_t     gpio_i,
	output gpio_t          gpio_o,
	output gpio_t          gpio_oe_o,
	output logic           irq_o,
	output irq_id_t        irq_id_o
);

	logic [1:0] rst_sync_q;
	logic       rst_n;
	logic       dev_cyc;
	logic       dev_we;
	bus_data_t  dev_dat;
	bus_sel_t   dev_sel;
	logic       ram_stb;
	logic       gpio_stb;
	logic       timer_stb;
	logic       plic_stb;
	ram_addr_t  ram_adr;
	reg_addr_t  reg_adr;
	bus_data_t  ram_dat;
	bus_data_t  gpio_dat;
	bus_data_t  timer_dat;
	bus_data_t  plic_dat;
	logic       ram_ack;
	logic       gpio_ack;
	logic       timer_ack;
	logic       plic_ack;
	gpio_t      gpio_intr;
	logic       timer_intr;

	////////////////////////////////////////
	// Reset synchronizer

	always_ff @(posedge usb_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rst_sync_q <= 2'b00;
		end else begin
			rst_sync_q <= {rst_sync_q[0], 1'b1};
		end
	end

	assign rst_n = rst_sync_q[1];

	////////////////////////////////////////
	// Bus and devices

	wb_xbar u_xbar (
		.usb_clk, .rst_n_i(rst_n),
		.wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_sel_i,
		.wb_dat_o, .wb_ack_o, .wb_err_o,
		.cyc_o(dev_cyc), .we_o(dev_we), .dat_o(dev_dat), .sel_o(dev_sel),
		.ram_stb_o(ram_stb), .gpio_stb_o(gpio_stb),
		.timer_stb_o(timer_stb), .plic_stb_o(plic_stb),
		.ram_adr_o(ram_adr), .reg_adr_o(reg_adr),
		.ram_dat_i(ram_dat), .ram_ack_i(ram_ack),
		.gpio_dat_i(gpio_dat), .gpio_ack_i(gpio_ack),
		.timer_dat_i(timer_dat), .timer_ack_i(timer_ack),
		.plic_dat_i(plic_dat), .plic_ack_i(plic_ack)
	);

	ram_main u_ram_main (
		.usb_clk, .rst_n_i(rst_n), .cyc_i(dev_cyc), .stb_i(ram_stb), .we_i(dev_we),
		.adr_i(ram_adr), .dat_i(dev_dat), .sel_i(dev_sel), .dat_o(ram_dat), .ack_o(ram_ack)
	);

	gpio u_gpio (
		.usb_clk, .rst_n_i(rst_n), .cyc_i(dev_cyc), .stb_i(gpio_stb), .we_i(dev_we),
		.adr_i(reg_adr), .dat_i(dev_dat), .dat_o(gpio_dat), .ack_o(gpio_ack),
		.gpio_i, .gpio_o, .gpio_oe_o, .intr_o(gpio_intr)
	);

	rv_timer u_rv_timer (
		.usb_clk, .rst_n_i(rst_n), .cyc_i(dev_cyc), .stb_i(timer_stb), .we_i(dev_we),
		.adr_i(reg_adr), .dat_i(dev_dat), .dat_o(timer_dat), .ack_o(timer_ack),
		.intr_o(timer_intr)
	);

	rv_plic u_rv_plic (
		.usb_clk, .rst_n_i(rst_n), .cyc_i(dev_cyc), .stb_i(plic_stb), .we_i(dev_we),
		.adr_i(reg_adr), .dat_i(dev_dat), .dat_o(plic_dat), .ack_o(plic_ack),
		.gpio_intr_i(gpio_intr), .timer_intr_i(timer_intr), .irq_o, .irq_id_o
	);

endmodule

`default_nettype wire

// File: src/rv_plic.sv
`timescale 1ns/1ps
`default_nettype none

module rv_plic
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;
(
	input  wire logic      usb_clk,
	input  wire logic      rst_n_i,
	input  wire logic      cyc_i,
	input  wire logic      stb_i,
	input  wire logic      we_i,
	input  wire reg_addr_t adr_i,
	input  wire bus_data_t dat_i,
	output bus_data_t      dat_o,
	output logic           ack_o,
	input  wire gpio_t     gpio_intr_i,
	input  wire logic      timer_intr_i,
	output logic           irq_o,
	output irq_id_t        irq_id_o
);

	logic     access;
	logic     rd_claim;
	logic     wr_claim;
	irq_src_t src;
	irq_src_t pending_q;
	irq_src_t enable_q;
	irq_src_t in_service_q;
	irq_src_t eligible;
	irq_id_t  claim_id;

	assign src[int'(IRQ_ID_GPIO0) - 1 +: GPIO_W] = gpio_intr_i;
	assign src[int'(IRQ_ID_TIMER) - 1]            = timer_intr_i;

	assign access   = cyc_i & stb_i & ~ack_o;
	assign rd_claim = access & ~we_i & (adr_i == PLIC_CLAIM);
	assign wr_claim = access & we_i & (adr_i == PLIC_CLAIM);
	assign eligible = pending_q & enable_q & ~in_service_q;

	// Lowest id wins.
	always_comb begin
		claim_id = '0;
		for (int k = N_IRQ_SRC - 1; k >= 0; k--) begin
			if (eligible[k]) begin
				claim_id = irq_id_t'(k) + IRQ_ID_GPIO0;
			end
		end
	end

	always_ff @(posedge usb_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_o        <= 1'b0;
			pending_q    <= '0;
			enable_q     <= '0;
			in_service_q <= '0;
		end else begin
			ack_o     <= access;
			pending_q <= src; // Level sources are resampled every cycle.
			if (access && we_i && adr_i == PLIC_ENABLE) begin
				enable_q <= dat_i[N_IRQ_SRC-1:0];
			end
			for (int k = 0; k < N_IRQ_SRC; k++) begin
				if (rd_claim && claim_id == irq_id_t'(k) + IRQ_ID_GPIO0) begin
					in_service_q[k] <= 1'b1;
				end
				if (wr_claim && dat_i == bus_data_t'(irq_id_t'(k) + IRQ_ID_GPIO0)) begin
					in_service_q[k] <= 1'b0; // Complete.
				end
			end
		end
	end

	always_ff @(posedge usb_clk) begin
		if (access && !we_i) begin
			case (adr_i)
				PLIC_PENDING: dat_o <= bus_data_t'(pending_q);
				PLIC_ENABLE:  dat_o <= bus_data_t'(enable_q);
				PLIC_CLAIM:   dat_o <= bus_data_t'(claim_id);
				default:      dat_o <= '0;
			endcase
		end
	end

	assign irq_o    = |eligible;
	assign irq_id_o = claim_id;

endmodule

`default_nettype wire

// File: src/rv_timer.sv
`timescale 1ns/1ps
`default_nettype none

module rv_timer
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;
(
	input  wire logic      usb_clk,
	input  wire logic      rst_n_i,
	input  wire logic      cyc_i,
	input  wire logic      stb_i,
	input  wire logic      we_i,
	input  wire reg_addr_t adr_i,
	input  wire bus_data_t dat_i,
	output bus_data_t      dat_o,
	output logic           ack_o,
	output logic           intr_o
);

	logic      access;
	logic      wr;
	logic      enable_q;
	logic      intr_en_q;
	bus_data_t mtime_q;
	bus_data_t mtimecmp_q;

	assign access = cyc_i & stb_i & ~ack_o;
	assign wr     = access & we_i;

	always_ff @(posedge usb_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_o      <= 1'b0;
			enable_q   <= 1'b0;
			intr_en_q  <= 1'b0;
			mtime_q    <= '0;
			mtimecmp_q <= '0;
			intr_o     <= 1'b0;
		end else begin
			ack_o  <= access;
			intr_o <= intr_en_q & (mtime_q >= mtimecmp_q); // Registered compare.
			if (wr && adr_i == TIMER_MTIME) begin
				mtime_q <= dat_i; // Software write wins over the tick.
			end else if (enable_q) begin
				mtime_q <= mtime_q + 1'b1;
			end
			if (wr) begin
				case (adr_i)
					TIMER_CTRL:        enable_q   <= dat_i[0];
					TIMER_MTIMECMP:    mtimecmp_q <= dat_i;
					TIMER_INTR_ENABLE: intr_en_q  <= dat_i[0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge usb_clk) begin
		if (access && !we_i) begin
			case (adr_i)
				TIMER_CTRL:        dat_o <= bus_data_t'(enable_q);
				TIMER_MTIME:       dat_o <= mtime_q;
				TIMER_MTIMECMP:    dat_o <= mtimecmp_q;
				TIMER_INTR_ENABLE: dat_o <= bus_data_t'(intr_en_q);
				default:           dat_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/gpio.sv
`timescale 1ns/1ps
`default_nettype none

module gpio
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;
(
	input  wire logic      usb_clk,
	input  wire logic      rst_n_i,
	input  wire logic      cyc_i,
	input  wire logic      stb_i,
	input  wire logic      we_i,
	input  wire reg_addr_t adr_i,
	input  wire bus_data_t dat_i,
	output bus_data_t      dat_o,
	output logic           ack_o,
	input  wire gpio_t     gpio_i,
	output gpio_t          gpio_o,
	output gpio_t          gpio_oe_o,
	output gpio_t          intr_o
);

	logic  access;
	logic  wr;
	gpio_t in_meta_q;
	gpio_t in_sync_q;
	gpio_t in_prev_q;
	gpio_t data_out_q;
	gpio_t data_oe_q;
	gpio_t intr_en_q;
	gpio_t intr_state_q;
	gpio_t rise;
	gpio_t clr;

	assign access = cyc_i & stb_i & ~ack_o;
	assign wr     = access & we_i;
	assign rise   = in_sync_q & ~in_prev_q;
	assign clr    = (wr && adr_i == GPIO_INTR_STATE) ? dat_i[GPIO_W-1:0] : '0; // W1C.

	always_ff @(posedge usb_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_o        <= 1'b0;
			in_meta_q    <= '0;
			in_sync_q    <= '0;
			in_prev_q    <= '0;
			data_out_q   <= '0;
			data_oe_q    <= '0;
			intr_en_q    <= '0;
			intr_state_q <= '0;
		end else begin
			ack_o        <= access;
			in_meta_q    <= gpio_i;
			in_sync_q    <= in_meta_q;
			in_prev_q    <= in_sync_q;
			intr_state_q <= (intr_state_q & ~clr) | rise;
			if (wr) begin
				case (adr_i)
					GPIO_DATA_OUT:    data_out_q <= dat_i[GPIO_W-1:0];
					GPIO_DATA_OE:     data_oe_q  <= dat_i[GPIO_W-1:0];
					GPIO_INTR_ENABLE: intr_en_q  <= dat_i[GPIO_W-1:0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge usb_clk) begin
		if (access && !we_i) begin
			case (adr_i)
				GPIO_DATA_IN:     dat_o <= bus_data_t'(in_sync_q);
				GPIO_DATA_OUT:    dat_o <= bus_data_t'(data_out_q);
				GPIO_DATA_OE:     dat_o <= bus_data_t'(data_oe_q);
				GPIO_INTR_ENABLE: dat_o <= bus_data_t'(intr_en_q);
				GPIO_INTR_STATE:  dat_o <= bus_data_t'(intr_state_q);
				default:          dat_o <= '0;
			endcase
		end
	end

	assign gpio_o    = data_out_q;
	assign gpio_oe_o = data_oe_q;
	assign intr_o    = intr_state_q & intr_en_q;

endmodule

`default_nettype wire

// File: src/ram_main.sv
`timescale 1ns/1ps
`default_nettype none

module ram_main
	import soc_bus_pkg::*;
(
	input  wire logic      usb_clk,
	input  wire logic      rst_n_i,
	input  wire logic      cyc_i,
	input  wire logic      stb_i,
	input  wire logic      we_i,
	input  wire ram_addr_t adr_i,
	input  wire bus_data_t dat_i,
	input  wire bus_sel_t  sel_i,
	output bus_data_t      dat_o,
	output logic           ack_o
);

	bus_data_t mem [RAM_WORDS];
	logic      access;

	assign access = cyc_i & stb_i & ~ack_o; // One beat per request.

	always_ff @(posedge usb_clk) begin
		if (access) begin
			if (we_i) begin
				for (int b = 0; b < $bits(bus_sel_t); b++) begin
					if (sel_i[b]) begin
						mem[adr_i][8*b +: 8] <= dat_i[8*b +: 8];
					end
				end
			end else begin
				dat_o <= mem[adr_i];
			end
		end
	end

	always_ff @(posedge usb_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= access;
		end
	end

endmodule

`default_nettype wire

// File: src/wb_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module wb_xbar
	import soc_bus_pkg::*;
(
	input  wire logic      usb_clk,
	input  wire logic      rst_n_i,
	input  wire logic      wb_cyc_i,
	input  wire logic      wb_stb_i,
	input  wire logic      wb_we_i,
	input  wire bus_addr_t wb_adr_i,
	input  wire bus_data_t wb_dat_i,
	input  wire bus_sel_t  wb_sel_i,
	output bus_data_t      wb_dat_o,
	output logic           wb_ack_o,
	output logic           wb_err_o,
	output logic           cyc_o,
	output logic           we_o,
	output bus_data_t      dat_o,
	output bus_sel_t       sel_o,
	output logic           ram_stb_o,
	output logic           gpio_stb_o,
	output logic           timer_stb_o,
	output logic           plic_stb_o,
	output ram_addr_t      ram_adr_o,
	output reg_addr_t      reg_adr_o,
	input  wire bus_data_t ram_dat_i,
	input  wire logic      ram_ack_i,
	input  wire bus_data_t gpio_dat_i,
	input  wire logic      gpio_ack_i,
	input  wire bus_data_t timer_dat_i,
	input  wire logic      timer_ack_i,
	input  wire bus_data_t plic_dat_i,
	input  wire logic      plic_ack_i
);

	logic hit_ram;
	logic hit_gpio;
	logic hit_timer;
	logic hit_plic;
	logic miss;
	logic err_q;

	assign hit_ram   = (wb_adr_i & ~ADDR_MASK_RAM_MAIN) == ADDR_SPACE_RAM_MAIN;
	assign hit_gpio  = (wb_adr_i & ~ADDR_MASK_PERI) == ADDR_SPACE_GPIO;
	assign hit_timer = (wb_adr_i & ~ADDR_MASK_PERI) == ADDR_SPACE_TIMER;
	assign hit_plic  = (wb_adr_i & ~ADDR_MASK_PERI) == ADDR_SPACE_PLIC;
	assign miss      = ~(hit_ram | hit_gpio | hit_timer | hit_plic);

	assign cyc_o       = wb_cyc_i;
	assign we_o        = wb_we_i;
	assign dat_o       = wb_dat_i;
	assign sel_o       = wb_sel_i;
	assign ram_stb_o   = wb_stb_i & hit_ram;
	assign gpio_stb_o  = wb_stb_i & hit_gpio;
	assign timer_stb_o = wb_stb_i & hit_timer;
	assign plic_stb_o  = wb_stb_i & hit_plic;
	assign ram_adr_o   = wb_adr_i[$bits(ram_addr_t)+1:2]; // Byte to word address.
	assign reg_adr_o   = wb_adr_i[$bits(reg_addr_t)+1:2];

	// Unmapped accesses get err with the timing of a device ack.
	always_ff @(posedge usb_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			err_q <= 1'b0;
		end else begin
			err_q <= wb_cyc_i & wb_stb_i & miss & ~err_q;
		end
	end

	always_comb begin
		wb_dat_o = '0; // Misses read as zero.
		wb_ack_o = 1'b0;
		if (hit_ram) begin
			wb_dat_o = ram_dat_i;
			wb_ack_o = ram_ack_i;
		end else if (hit_gpio) begin
			wb_dat_o = gpio_dat_i;
			wb_ack_o = gpio_ack_i;
		end else if (hit_timer) begin
			wb_dat_o = timer_dat_i;
			wb_ack_o = timer_ack_i;
		end else if (hit_plic) begin
			wb_dat_o = plic_dat_i;
			wb_ack_o = plic_ack_i;
		end
	end

	assign wb_err_o = err_q;

endmodule

`default_nettype wire

// File: src/soc_periph_pkg.sv
`default_nettype none

package soc_periph_pkg;
	import soc_bus_pkg::*;

	localparam int GPIO_W = 8;
	typedef logic [GPIO_W-1:0] gpio_t;

	localparam int N_IRQ_SRC = 9;
	typedef logic [N_IRQ_SRC-1:0] irq_src_t;
	typedef logic [3:0]           irq_id_t; // Zero means none.

	localparam irq_id_t IRQ_ID_GPIO0 = 4'd1; // Pin k has id k+1.
	localparam irq_id_t IRQ_ID_TIMER = 4'd9;

	////////////////////////////////////////
	// Register word offsets

	localparam reg_addr_t GPIO_DATA_IN     = 10'd0;
	localparam reg_addr_t GPIO_DATA_OUT    = 10'd1;
	localparam reg_addr_t GPIO_DATA_OE     = 10'd2;
	localparam reg_addr_t GPIO_INTR_ENABLE = 10'd3;
	localparam reg_addr_t GPIO_INTR_STATE  = 10'd4;

	localparam reg_addr_t TIMER_CTRL        = 10'd0;
	localparam reg_addr_t TIMER_MTIME       = 10'd1;
	localparam reg_addr_t TIMER_MTIMECMP    = 10'd2;
	localparam reg_addr_t TIMER_INTR_ENABLE = 10'd3;

	localparam reg_addr_t PLIC_PENDING = 10'd0;
	localparam reg_addr_t PLIC_ENABLE  = 10'd1;
	localparam reg_addr_t PLIC_CLAIM   = 10'd2;

endpackage

`default_nettype wire

// File: src/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

	localparam int BUS_AW = 32;
	localparam int BUS_DW = 32;

	typedef logic [BUS_AW-1:0]   bus_addr_t;
	typedef logic [BUS_DW-1:0]   bus_data_t;
	typedef logic [BUS_DW/8-1:0] bus_sel_t;

	localparam int RAM_WORDS = 256;

	typedef logic [$clog2(RAM_WORDS)-1:0] ram_addr_t; // Word index into RAM.
	typedef logic [9:0]                   reg_addr_t; // Word offset in a 4 KiB window.

	////////////////////////////////////////
	// Address map

	localparam bus_addr_t ADDR_SPACE_RAM_MAIN = 32'h1000_0000;
	localparam bus_addr_t ADDR_MASK_RAM_MAIN  = 32'h0000_03ff;

	localparam bus_addr_t ADDR_SPACE_GPIO  = 32'h4000_0000;
	localparam bus_addr_t ADDR_SPACE_PLIC  = 32'h4009_0000;
	localparam bus_addr_t ADDR_SPACE_TIMER = 32'h4010_0000;
	localparam bus_addr_t ADDR_MASK_PERI   = 32'h0000_0fff; // Same size for all peripherals.

endpackage

`default_nettype wire
